// ==== verilog/rv32i_pkg.sv ====
package rv32i_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] inst_t;            // One fetched instruction word
    typedef logic [XLEN-1:0] addr_t;            // Byte address

    // Fetch starts here out of reset
    localparam addr_t RESET_PC = 32'h1eceb000;

    // Sequential fetch step
    localparam addr_t INST_BYTES = 32'd4;

endpackage : rv32i_pkg

// ==== verilog/mem_pkg.sv ====
package mem_pkg;

    localparam int BEAT_BITS        = 64;
    localparam int BEATS_PER_LINE   = 4;
    localparam int LINE_BITS        = BEAT_BITS * BEATS_PER_LINE;
    localparam int LINE_OFFSET_BITS = 5;                        // 32-byte lines
    localparam int WORD_SEL_BITS    = LINE_OFFSET_BITS - 2;     // 32-bit words per line

    typedef logic [BEAT_BITS-1:0] beat_t;           // One burst beat
    typedef logic [LINE_BITS-1:0] line_t;           // Whole cacheline

    // Address split
    typedef logic [WORD_SEL_BITS-1:0] word_sel_t;           // Word within a line
    typedef logic [31-LINE_OFFSET_BITS:0] line_addr_t;      // Line number, offset dropped

endpackage : mem_pkg

// ==== verilog/mem_port_if.sv ====
`timescale 1ns/1ps

interface mem_port_if #(
    parameter type data_t = rv32i_pkg::inst_t
);
    import rv32i_pkg::*;

    addr_t  addr;       // Valid with read
    logic   read;       // One-cycle request strobe
    data_t  rdata;      // Valid with resp
    logic   resp;       // One-cycle response strobe

    modport requester (
        output addr,
        output read,
        input  rdata,
        input  resp
    );

    modport responder (
        input  addr,
        input  read,
        output rdata,
        output resp
    );

endinterface : mem_port_if

// ==== verilog/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit #(
    parameter rv32i_pkg::addr_t RESET_PC = '0
) (
    input  logic            clk,
    input  logic            rst,

    mem_port_if.requester   fetch_port,

    input  logic            q_almost_full_i
);
    import rv32i_pkg::*;

    addr_t  pc;
    logic   pending;        // Request issued, response not yet seen
    logic   start;

    // A new request goes out as soon as nothing is in flight and the
    // queue can still take the word. The last free queue slot is kept
    // for the request that is already outstanding.
    assign start = !pending && !q_almost_full_i;

    assign fetch_port.read = start;
    assign fetch_port.addr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= RESET_PC;
            pending <= 1'b0;
        end else begin
            if (start) begin
                pending <= 1'b1;
            end else if (fetch_port.resp) begin
                pending <= 1'b0;
            end

            if (fetch_port.resp) begin
                pc <= pc + INST_BYTES;      // Strictly sequential
            end
        end
    end

endmodule : fetch_unit

// ==== verilog/icache.sv ====
`timescale 1ns/1ps

module icache #(
    parameter int NUM_SETS = 16
) (
    input  logic            clk,
    input  logic            rst,

    mem_port_if.responder   fetch_port,
    mem_port_if.requester   line_port
);
    import rv32i_pkg::*;
    import mem_pkg::*;

    localparam int INDEX_BITS = $clog2(NUM_SETS);
    localparam int TAG_BITS   = $bits(line_addr_t) - INDEX_BITS;

    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [TAG_BITS-1:0]   tag_t;

    typedef enum logic [1:0] {
        IDLE,
        MISS_WAIT,
        RESPOND
    } state_t;

    state_t             state;
    logic [NUM_SETS-1:0] valid_q;
    tag_t               tag_q  [NUM_SETS];
    line_t              data_q [NUM_SETS];

    addr_t              req_addr;       // Address of the request in progress
    inst_t              rdata_q;
    logic               line_read_q;

    line_addr_t         lk_line, rq_line;
    index_t             lk_index, rq_index;
    tag_t               lk_tag, rq_tag;
    word_sel_t          lk_word, rq_word;
    logic               hit;
    logic               accept;
    logic               refill;

    function automatic inst_t pick_word(line_t line, word_sel_t sel);
        return line[32*int'(sel) +: 32];
    endfunction

    // Lookup on the incoming address
    assign lk_line  = fetch_port.addr[31:LINE_OFFSET_BITS];
    assign lk_index = lk_line[INDEX_BITS-1:0];
    assign lk_tag   = lk_line[$bits(line_addr_t)-1:INDEX_BITS];
    assign lk_word  = fetch_port.addr[LINE_OFFSET_BITS-1:2];

    // Same split on the latched address for the refill
    assign rq_line  = req_addr[31:LINE_OFFSET_BITS];
    assign rq_index = rq_line[INDEX_BITS-1:0];
    assign rq_tag   = rq_line[$bits(line_addr_t)-1:INDEX_BITS];
    assign rq_word  = req_addr[LINE_OFFSET_BITS-1:2];

    assign hit    = valid_q[lk_index] && (tag_q[lk_index] == lk_tag);
    assign accept = (state == IDLE) && fetch_port.read;
    assign refill = (state == MISS_WAIT) && line_port.resp;

    assign fetch_port.rdata = rdata_q;
    assign fetch_port.resp  = (state == RESPOND);
    assign line_port.read   = line_read_q;
    assign line_port.addr   = {rq_line, {LINE_OFFSET_BITS{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= IDLE;
            valid_q     <= '0;
            line_read_q <= 1'b0;
        end else begin
            line_read_q <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        if (hit) begin
                            state <= RESPOND;
                        end else begin
                            line_read_q <= 1'b1;        // Line request next cycle
                            state       <= MISS_WAIT;
                        end
                    end
                end
                MISS_WAIT: begin
                    if (refill) begin
                        valid_q[rq_index] <= 1'b1;
                        state             <= RESPOND;
                    end
                end
                RESPOND: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr <= fetch_port.addr;
            rdata_q  <= pick_word(data_q[lk_index], lk_word);   // Only used on a hit
        end
        if (refill) begin
            data_q[rq_index] <= line_port.rdata;
            tag_q[rq_index]  <= rq_tag;
            rdata_q          <= pick_word(line_port.rdata, rq_word);
        end
    end

endmodule : icache

// ==== verilog/cacheline_adapter.sv ====
`timescale 1ns/1ps

module cacheline_adapter (
    input  logic                clk,
    input  logic                rst,

    mem_port_if.responder       line_port,

    output rv32i_pkg::addr_t    bmem_addr_o,
    output logic                bmem_read_o,
    input  logic                bmem_ready_i,

    input  rv32i_pkg::addr_t    bmem_raddr_i,
    input  mem_pkg::beat_t      bmem_rdata_i,
    input  logic                bmem_rvalid_i
);
    import rv32i_pkg::*;
    import mem_pkg::*;

    localparam int CNT_BITS = $clog2(BEATS_PER_LINE);

    addr_t              req_addr;
    line_addr_t         req_line;
    logic               req_pending;    // Line requested, burst not yet issued
    logic               busy;           // Burst issued, beats still due
    logic [CNT_BITS-1:0] beat_cnt;
    line_t              line_q;
    logic               resp_q;
    logic               beat_ok;
    logic               last_beat;

    assign req_line    = line_port.addr[31:LINE_OFFSET_BITS];
    assign bmem_read_o = req_pending && bmem_ready_i;
    assign bmem_addr_o = req_addr;

    // Beats for some other address are not ours
    assign beat_ok   = busy && bmem_rvalid_i && (bmem_raddr_i == req_addr);
    assign last_beat = beat_ok && (beat_cnt == CNT_BITS'(BEATS_PER_LINE - 1));

    assign line_port.rdata = line_q;
    assign line_port.resp  = resp_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_pending <= 1'b0;
            busy        <= 1'b0;
            beat_cnt    <= '0;
            resp_q      <= 1'b0;
        end else begin
            resp_q <= last_beat;
            if (line_port.read) begin
                req_pending <= 1'b1;
            end else if (bmem_read_o) begin
                req_pending <= 1'b0;
            end
            if (bmem_read_o) begin
                busy     <= 1'b1;
                beat_cnt <= '0;
            end else if (beat_ok) begin
                busy     <= !last_beat;
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (line_port.read) begin
            req_addr <= {req_line, {LINE_OFFSET_BITS{1'b0}}};
        end
        if (beat_ok) begin
            line_q <= {bmem_rdata_i, line_q[$bits(line_t)-1:$bits(beat_t)]};  // Lowest beat first
        end
    end

endmodule : cacheline_adapter

// ==== verilog/inst_queue.sv ====
`timescale 1ns/1ps

module inst_queue #(
    parameter type data_t      = rv32i_pkg::inst_t,
    parameter int  QUEUE_DEPTH = 16
) (
    input  logic    clk,
    input  logic    rst,

    input  data_t   wdata_i,
    input  logic    enqueue_i,

    output data_t   rdata_o,
    input  logic    dequeue_i,

    output logic    full_o,
    output logic    almost_full_o,
    output logic    empty_o
);
    localparam int PTR_BITS = $clog2(QUEUE_DEPTH);
    localparam int CNT_BITS = $clog2(QUEUE_DEPTH + 1);

    data_t               mem [QUEUE_DEPTH];
    logic [PTR_BITS-1:0] head, tail;
    logic [CNT_BITS-1:0] count;
    logic                do_enq, do_deq;

    assign do_enq = enqueue_i && !full_o;
    assign do_deq = dequeue_i && !empty_o;

    assign rdata_o       = mem[head];                               // Oldest entry
    assign full_o        = (count == CNT_BITS'(QUEUE_DEPTH));
    assign almost_full_o = (count >= CNT_BITS'(QUEUE_DEPTH - 1));   // One slot left
    assign empty_o       = (count == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (do_enq) begin
                tail <= (tail == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (do_deq) begin
                head <= (head == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : head + 1'b1;
            end
            case ({do_enq, do_deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem[tail] <= wdata_i;
        end
    end

endmodule : inst_queue

// ==== verilog/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top #(
    parameter int               NUM_SETS    = 16,
    parameter int               QUEUE_DEPTH = 16,
    parameter rv32i_pkg::addr_t RESET_PC    = rv32i_pkg::RESET_PC
) (
    input  logic                clk,
    input  logic                rst,

    output rv32i_pkg::addr_t    bmem_addr_o,
    output logic                bmem_read_o,
    input  logic                bmem_ready_i,
    input  rv32i_pkg::addr_t    bmem_raddr_i,
    input  mem_pkg::beat_t      bmem_rdata_i,
    input  logic                bmem_rvalid_i,

    output rv32i_pkg::inst_t    inst_o,
    output logic                inst_valid_o,
    input  logic                deq_i
);
    import rv32i_pkg::*;
    import mem_pkg::*;

    logic q_almost_full;
    logic q_empty;

    mem_port_if #(.data_t(inst_t)) fetch_port ();
    mem_port_if #(.data_t(line_t)) line_port ();

    fetch_unit #(.RESET_PC(RESET_PC)) fetch_unit_i (
        .clk             (clk),
        .rst             (rst),
        .fetch_port      (fetch_port.requester),
        .q_almost_full_i (q_almost_full)
    );

    icache #(.NUM_SETS(NUM_SETS)) icache_i (
        .clk        (clk),
        .rst        (rst),
        .fetch_port (fetch_port.responder),
        .line_port  (line_port.requester)
    );

    cacheline_adapter cacheline_adapter_i (
        .clk           (clk),
        .rst           (rst),
        .line_port     (line_port.responder),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_raddr_i  (bmem_raddr_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i)
    );

    // Cache responses go straight into the queue
    inst_queue #(.data_t(inst_t), .QUEUE_DEPTH(QUEUE_DEPTH)) inst_queue_i (
        .clk           (clk),
        .rst           (rst),
        .wdata_i       (fetch_port.rdata),
        .enqueue_i     (fetch_port.resp),
        .rdata_o       (inst_o),
        .dequeue_i     (deq_i),
        .full_o        (),
        .almost_full_o (q_almost_full),
        .empty_o       (q_empty)
    );

    assign inst_valid_o = !q_empty;

endmodule : fetch_top

// ==== bench/fetch_assert.sv ====
`timescale 1ns/1ps

module fetch_assert (
    input logic clk,
    input logic rst,
    input logic bmem_read_i,
    input logic bmem_ready_i,
    input logic bmem_rvalid_i,
    input logic inst_valid_i
);
    import mem_pkg::*;

    logic [2:0] beats_due;          // Beats still owed for the open burst
    int         fail_count = 0;     // Failed assertions so far

    always_ff @(posedge clk) begin
        if (rst) begin
            beats_due <= '0;
        end else if (bmem_read_i) begin
            beats_due <= 3'(BEATS_PER_LINE);
        end else if (bmem_rvalid_i && beats_due != '0) begin
            beats_due <= beats_due - 1'b1;
        end
    end

    read_with_ready: assert property (@(posedge clk) disable iff (rst)
        bmem_read_i |-> bmem_ready_i)
        else begin
            fail_count++;
            $error("bmem_read_o raised while bmem_ready_i is low");
        end

    one_burst_open: assert property (@(posedge clk) disable iff (rst)
        bmem_read_i |-> (beats_due == '0))
        else begin
            fail_count++;
            $error("Second burst read issued before four beats returned");
        end

    quiet_in_reset: assert property (@(posedge clk)
        (rst && $past(rst)) |-> !inst_valid_i)
        else begin
            fail_count++;
            $error("inst_valid_o high during reset");
        end

endmodule : fetch_assert

bind fetch_top fetch_assert fetch_assert_i (
    .clk           (clk),
    .rst           (rst),
    .bmem_read_i   (bmem_read_o),
    .bmem_ready_i  (bmem_ready_i),
    .bmem_rvalid_i (bmem_rvalid_i),
    .inst_valid_i  (inst_valid_o)
);

// ==== bench/tb_fetch.sv ====
`timescale 1ns/1ps

module tb_fetch;
    import rv32i_pkg::*;
    import mem_pkg::*;

    localparam int    RESET_CYCLES    = 5;
    localparam int    FILL_CYCLES     = 128;        // Ample time to fill the queue
    localparam int    HOLD_CYCLES     = 50;
    localparam int    CYCLES_PER_INST = 40;
    localparam addr_t LINE_BASE       = RESET_PC & ~addr_t'((1 << LINE_OFFSET_BITS) - 1);
    localparam string PATTERN_FILE    = "bench/fetch_patterns.hex";

    logic   clk, rst, deq, inst_valid;
    logic   bmem_read, bmem_ready, bmem_rvalid;
    addr_t  bmem_addr, bmem_raddr;
    beat_t  bmem_rdata;
    inst_t  inst;

    beat_t  image [0:63];           // Entry 0 holds the word count
    inst_t  got [$];                // Words popped by the consumer
    addr_t  addr_log [$];           // Burst addresses in issue order
    integer seed;
    int     n_words, n_beats;
    int     errors, checks, tests_run, tests_failed;
    int     cycles = 0;
    int     cycle_limit = 0;
    logic   mem_busy = 1'b0;

    fetch_top uut (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_o   (bmem_addr),
        .bmem_read_o   (bmem_read),
        .bmem_ready_i  (bmem_ready),
        .bmem_raddr_i  (bmem_raddr),
        .bmem_rdata_i  (bmem_rdata),
        .bmem_rvalid_i (bmem_rvalid),
        .inst_o        (inst),
        .inst_valid_o  (inst_valid),
        .deq_i         (deq)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("** FAIL **");
            $finish;
        end
    end

    // Records each word that the next rising edge pops
    always @(negedge clk) begin
        if (rst === 1'b0 && inst_valid === 1'b1 && deq === 1'b1) begin
            got.push_back(inst);
        end
    end

    function automatic beat_t beat_at(addr_t a);
        addr_t offs;
        offs = a - RESET_PC;
        if (a >= RESET_PC && (offs >> 3) < addr_t'(n_beats)) begin
            return image[1 + int'(offs >> 3)];
        end
        return {~(a + 32'd4), ~a};          // Fill past the image
    endfunction

    function automatic inst_t image_word(int n);
        beat_t b;
        b = image[1 + n / 2];
        return (n % 2 == 0) ? b[31:0] : b[63:32];
    endfunction

    task automatic serve_burst(input addr_t line_addr);
        int rnd;
        rnd = $random(seed);
        repeat (2 + (rnd & 3)) @(posedge clk);
        for (int b = 0; b < BEATS_PER_LINE; b++) begin
            rnd = $random(seed);
            if (rnd[0]) begin               // Single-cycle gap
                bmem_rvalid <= 1'b0;
                @(posedge clk);
            end
            bmem_rvalid <= 1'b1;
            bmem_raddr  <= line_addr;
            bmem_rdata  <= beat_at(line_addr + addr_t'(8 * b));
            @(posedge clk);
        end
        bmem_rvalid <= 1'b0;
    endtask

    initial begin : memory_model
        addr_t line_addr;
        forever begin
            @(negedge clk);
            if (bmem_read === 1'b1 && rst === 1'b0) begin
                line_addr = bmem_addr;
                addr_log.push_back(line_addr);
                @(posedge clk);
                mem_busy   <= 1'b1;
                bmem_ready <= 1'b0;
                serve_burst(line_addr);
                mem_busy   <= 1'b0;
                bmem_ready <= 1'b1;
            end
        end
    end

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d errors", tests_run, name, errors - errors_before);
        end
    endtask

    task automatic reset_dut();
        while (mem_busy) @(posedge clk);
        rst <= 1'b1;
        deq <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        got.delete();
        addr_log.delete();
        rst <= 1'b0;
    endtask

    // Pops until the whole image is out, then compares it word by word
    task automatic drain_and_compare(input bit random_deq);
        int rnd;
        while (got.size() < n_words) begin
            rnd = $random(seed);
            deq <= random_deq ? rnd[0] : 1'b1;
            @(posedge clk);
        end
        deq <= 1'b0;
        for (int i = 0; i < n_words; i++) begin
            check("inst_o", got[i], image_word(i));
        end
    endtask

    initial begin : main
        int err0;
        rst         = 1'b1;
        deq         = 1'b0;
        bmem_ready  = 1'b1;
        bmem_rvalid = 1'b0;
        bmem_raddr  = '0;
        bmem_rdata  = '0;
        seed        = 32'hdc87;
        {errors, checks, tests_run, tests_failed} = '0;
        $readmemh(PATTERN_FILE, image);
        n_words     = int'(image[0]);
        n_beats     = n_words / 2;
        cycle_limit = CYCLES_PER_INST * n_words;

        err0 = errors;
        reset_dut();
        @(negedge clk);
        check("inst_valid_o", 32'(inst_valid), 32'd0);
        check("bmem_read_o", 32'(bmem_read), 32'd0);
        @(posedge clk);
        while (addr_log.size() == 0) @(posedge clk);
        check("bmem_addr_o", addr_log[0], LINE_BASE);
        finish_test("reset state", err0);

        err0 = errors;
        drain_and_compare(1'b0);
        finish_test("in-order stream", err0);

        err0 = errors;
        if (addr_log.size() < (n_beats + BEATS_PER_LINE - 1) / BEATS_PER_LINE) begin
            errors++;
            $display("Fewer line reads seen than the image has lines");
        end
        foreach (addr_log[k]) begin
            check("bmem_addr_o", addr_log[k], LINE_BASE + addr_t'(32 * k));
        end
        finish_test("line order", err0);

        err0 = errors;
        reset_dut();
        @(negedge clk);
        while (inst_valid !== 1'b1) @(negedge clk);
        repeat (FILL_CYCLES + HOLD_CYCLES) @(negedge clk);
        check("inst_o", inst, image_word(0));       // Oldest word still at the head
        @(posedge clk);
        drain_and_compare(1'b0);
        finish_test("back-pressure", err0);

        err0 = errors;
        reset_dut();
        drain_and_compare(1'b1);
        finish_test("random consumer", err0);

        $display("Tests: %0d run, %0d failed; checks: %0d, errors: %0d, assertion failures: %0d",
                 tests_run, tests_failed, checks, errors, uut.fetch_assert_i.fail_count);
        if (errors == 0 && uut.fetch_assert_i.fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : tb_fetch

// ==== bench/fetch_patterns.hex ====
// First entry: number of instruction words in the image.
// Then one 64-bit beat per line from RESET_PC; low half is the earlier word.
0000000000000028
0020011300100093
0040021300300193
0060031300500293
0080041300700393
00a0051300900493
00c0061300b00593
00e0071300d00693
0100081300f00793
0120091301100893
01400a1301300993
01600b1301500a93
01800c1301700b93
01a00d1301900c93
01c00e1301b00d93
01e00f1301d00e93
0200009301f00f93
0220019302100113
0240029302300213
0260039302500313
0280049302700413

// ==== vlog.f ====
verilog/rv32i_pkg.sv
verilog/mem_pkg.sv
verilog/mem_port_if.sv
verilog/fetch_unit.sv
verilog/icache.sv
verilog/cacheline_adapter.sv
verilog/inst_queue.sv
verilog/fetch_top.sv
bench/fetch_assert.sv
bench/tb_fetch.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fetch
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary -j $(JOBS) $(VFLAGS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then echo "Simulation ended without a result"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
